/* filelist.f */
verilog/btc_spc_pkg.sv
verilog/btc_spc_row_fsm.sv
verilog/btc_spc_bit_counter.sv
verilog/btc_spc_row_sort.sv
verilog/btc_spc_lapri_mem.sv
verilog/btc_spc_hd_fifo.sv
verilog/btc_spc_decide.sv
verilog/btc_spc_engine.sv
tb/btc_spc_engine_tb.sv

/* tb/btc_spc_engine_tb.sv */
// ---------------------------------------------------------------------
// Testbench of the SPC min-sum engine
// Streams rows from the golden file and checks every output bit
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_engine_tb
  import btc_spc_pkg::*;
();

  // One expected output bit
  typedef struct packed {
    logic  sop;
    logic  eop;
    extr_t lextr;
    logic  bitdat;
    logic  biterr;
    logic  decfail;
  } out_exp_t;

  logic   iclk;
  logic   ireset;
  logic   istart;
  alpha_t ialpha;
  logic   ival;
  strb_t  istrb;
  llr_t   iLLR;
  extr_t  iLextr;
  logic   oval;
  strb_t  ostrb;
  extr_t  oLextr;
  logic   obitdat;
  logic   obiterr;
  logic   odecfail;

  // Golden rows and bits
  int row_alpha[$];
  int row_len[$];
  int bit_llr[$];
  int bit_ext[$];
  int exp_ext[$];
  int exp_bit[$];
  int exp_err[$];
  int exp_fail[$];

  out_exp_t exp_q[$];
  int       rows_out;
  int       checks;
  int       errors;
  int       limit;
  logic     loaded;

  btc_spc_engine UUT (
    .iclk     (iclk),
    .ireset   (ireset),
    .istart   (istart),
    .ialpha   (ialpha),
    .ival     (ival),
    .istrb    (istrb),
    .iLLR     (iLLR),
    .iLextr   (iLextr),
    .oval     (oval),
    .ostrb    (ostrb),
    .oLextr   (oLextr),
    .obitdat  (obitdat),
    .obiterr  (obiterr),
    .odecfail (odecfail)
  );

  // 4 ns clock
  always #2 iclk = ~iclk;

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------

  task automatic check_field(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic load_golden(output logic ok);
    int    fd;
    int    n;
    int    v0, v1, v2, v3, v4, v5;
    string line;
    ok = 1'b0;
    fd = $fopen("tb/btc_spc_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file tb/btc_spc_golden.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Skip blank and comment lines
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      if (line.getc(0) == "R") begin
        // Row header with alpha and length
        n = $sscanf(line, "R %d %d", v0, v1);
        if (n == 2) begin
          row_alpha.push_back(v0);
          row_len.push_back(v1);
        end
      end else begin
        // Bit inputs and expected results
        n = $sscanf(line, "%d %d %d %d %d %d", v0, v1, v2, v3, v4, v5);
        if (n == 6) begin
          bit_llr.push_back(v0);
          bit_ext.push_back(v1);
          exp_ext.push_back(v2);
          exp_bit.push_back(v3);
          exp_err.push_back(v4);
          exp_fail.push_back(v5);
        end
      end
    end
    $fclose(fd);
    ok = (row_len.size() > 0) && (bit_llr.size() > 0);
  endtask

  task automatic idle_cycle();
    @(negedge iclk);
    ival  = 1'b0;
    istrb = '0;
  endtask

  //--------------------------------------------------------------------
  // Output monitor checking in order against the expected queue
  //--------------------------------------------------------------------

  always @(negedge iclk) begin
    out_exp_t e;
    if (!ireset && oval) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("Output valid at %0t with no expected value left", $time);
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        check_field("sop", ostrb.sop, e.sop);
        check_field("eop", ostrb.eop, e.eop);
        check_field("oLextr", int'($signed(oLextr)), int'($signed(e.lextr)));
        check_field("obitdat", obitdat, e.bitdat);
        check_field("obiterr", obiterr, e.biterr);
        check_field("odecfail", odecfail, e.decfail);
      end
      // Row count seen at the output
      if (ostrb.eop) begin
        rows_out <= rows_out + 1;
      end
    end
  end

  // Watchdog
  initial begin
    wait (loaded);
    repeat (limit) @(posedge iclk);
    $display("Timeout: outputs not complete after %0d cycles", limit);
    $display("Finished with errors");
    $finish;
  end

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------

  initial begin
    int       k;
    int       gap;
    logic     ok;
    out_exp_t e;
    iclk     = 1'b0;
    ireset   = 1'b1;
    istart   = 1'b0;
    ialpha   = '0;
    ival     = 1'b0;
    istrb    = '0;
    iLLR     = '0;
    iLextr   = '0;
    rows_out = 0;
    checks   = 0;
    errors   = 0;
    loaded   = 1'b0;
    void'($urandom(98583));
    load_golden(ok);
    if (!ok) begin
      errors++;
      $display("Golden file holds no usable rows");
    end else begin
      // Four cycles per bit covers gaps and readout
      limit  = bit_llr.size() * 4 + 200;
      loaded = 1'b1;
      repeat (16) @(negedge iclk);
      ireset = 1'b0;
      // Clear pointers, counters and FIFO
      @(negedge iclk);
      istart = 1'b1;
      @(negedge iclk);
      istart = 1'b0;
      k = 0;
      for (int r = 0; r < row_len.size(); r++) begin
        for (int i = 0; i < row_len[r]; i++) begin
          // Random idle gap before each bit
          gap = $urandom_range(2);
          repeat (gap) idle_cycle();
          // Row eop only after the previous row has left
          if (i == row_len[r] - 1 && r > 0 && rows_out < r) begin
            idle_cycle();
            wait (rows_out >= r);
          end
          @(negedge iclk);
          ival      = 1'b1;
          istrb.sop = (i == 0);
          istrb.eop = (i == row_len[r] - 1);
          ialpha    = alpha_t'(row_alpha[r]);
          iLLR      = llr_t'(bit_llr[k]);
          iLextr    = extr_t'(bit_ext[k]);
          e.sop     = (i == 0);
          e.eop     = (i == row_len[r] - 1);
          e.lextr   = extr_t'(exp_ext[k]);
          e.bitdat  = (exp_bit[k] != 0);
          e.biterr  = (exp_err[k] != 0);
          e.decfail = (exp_fail[k] != 0);
          exp_q.push_back(e);
          k++;
        end
      end
      idle_cycle();
      // Drain the last row
      wait (rows_out == row_len.size());
      repeat (10) @(negedge iclk);
      assert (exp_q.size() == 0) else begin
        errors++;
        $display("%0d expected outputs never appeared", exp_q.size());
      end
    end
    $display("Rows: %0d, checks: %0d, errors: %0d", rows_out, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/btc_spc_golden.txt */
# Row line: R alpha length
# Bit line: llr lextr exp_lextr exp_bit exp_err exp_fail
R 2 4
5 4 1 0 0 0
-3 2 -1 1 0 0
2 -6 -2 1 1 0
6 0 1 0 0 0
R 4 3
-4 -3 2 1 0 1
3 2 -2 0 0 1
1 1 -5 1 1 1
R 7 5
15 31 5 0 0 0
-16 -32 -5 1 0 0
3 -5 -5 1 1 0
-2 4 6 0 1 0
0 10 5 0 0 0
R 0 2
-5 31 6 0 1 1
6 -32 -5 0 0 1
R 1 8
1 8 0 0 0 1
-1 -8 0 1 0 1
4 -3 0 0 0 1
-6 5 0 1 0 1
2 -1 0 0 0 1
7 12 0 0 0 1
-8 -2 0 1 0 1
0 0 -1 1 1 1
R 3 6
2 -20 -3 1 1 0
-3 16 3 0 1 0
10 10 3 0 0 0
-7 -4 -3 1 0 0
1 3 4 0 0 0
-2 9 3 0 1 0

/* verilog/btc_spc_bit_counter.sv */
// ---------------------------------------------------------------------
// Write and readout position counters of the SPC engine
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_bit_counter
  import btc_spc_pkg::*;
(
  input  logic     iclk,
  input  logic     ireset,
  input  logic     istart,
  input  logic     ival,
  input  logic     eop,
  input  logic     rd_en,
  input  bit_idx_t last_idx,
  output bit_idx_t wr_idx,
  output bit_idx_t rd_idx,
  output logic     rd_last
);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_idx <= '0;
      rd_idx <= '0;
    end else if (istart) begin
      wr_idx <= '0;
      rd_idx <= '0;
    end else begin
      // Accepted bits, restart after row end
      if (ival) begin
        wr_idx <= eop ? '0 : wr_idx + 1'b1;
      end
      // Readout cycles, wrap on last bit
      if (rd_en) begin
        rd_idx <= rd_last ? '0 : rd_idx + 1'b1;
      end
    end
  end

  assign rd_last = rd_en && (rd_idx == last_idx);

endmodule

`default_nettype wire

/* verilog/btc_spc_decide.sv */
// ---------------------------------------------------------------------
// SPC min-sum output stage
// Extrinsic, bit decision, bit error and decoding fail per bit
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_decide
  import btc_spc_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        rd_val,
  input  bit_idx_t    rd_idx,
  input  row_metric_t metric,
  input  extr_t       lapri,
  input  logic        hd_bit,
  output logic        hd_read,
  output logic        oval,
  output strb_t       ostrb,
  output extr_t       oLextr,
  output logic        obitdat,
  output logic        obiterr,
  output logic        odecfail
);

  logic                    val_d;
  bit_idx_t                idx_d;
  mag_t                    ext_mag;
  logic                    ext_sign;
  extr_t                   lextr;
  logic signed [cEXTR_W:0] dec_sum;
  logic                    bitdat;

  //--------------------------------------------------------------------
  // Align read request with memory data
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_d <= 1'b0;
    end else begin
      val_d <= rd_val;
    end
  end

  always_ff @(posedge iclk) begin
    idx_d <= rd_idx;
  end

  //--------------------------------------------------------------------
  // Min-sum rule
  //--------------------------------------------------------------------

  always_comb begin
    // Least reliable bit sees min1, all others min0
    ext_mag  = (idx_d == metric.min0_idx) ? metric.min1 : metric.min0;
    // Product of the other signs
    ext_sign = metric.prod_sign ^ lapri[cEXTR_W-1];
    lextr    = ext_sign ? extr_t'(-{1'b0, ext_mag}) : extr_t'({1'b0, ext_mag});
    dec_sum  = lapri + lextr;
    // Negative soft output gives 1
    bitdat   = dec_sum[cEXTR_W];
  end

  // One FIFO pop per output bit
  assign hd_read = val_d;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else begin
      oval <= val_d;
    end
  end

  always_ff @(posedge iclk) begin
    ostrb.sop <= val_d && (idx_d == '0);
    ostrb.eop <= val_d && (idx_d == metric.last_idx);
    oLextr    <= lextr;
    obitdat   <= bitdat;
    obiterr   <= bitdat ^ hd_bit;
    // Odd parity of Lapri hard decisions
    odecfail  <= metric.prod_sign;
  end

endmodule

`default_nettype wire

/* verilog/btc_spc_engine.sv */
// ---------------------------------------------------------------------
// SPC soft-in soft-out component decoder engine, min-sum
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_engine
  import btc_spc_pkg::*;
(
  input  logic   iclk,
  input  logic   ireset,
  input  logic   istart,
  input  alpha_t ialpha,
  input  logic   ival,
  input  strb_t  istrb,
  input  llr_t   iLLR,
  input  extr_t  iLextr,
  output logic   oval,
  output strb_t  ostrb,
  output extr_t  oLextr,
  output logic   obitdat,
  output logic   obiterr,
  output logic   odecfail
);

  logic        mem_write;
  extr_t       mem_wdat;
  extr_t       mem_rdat;
  logic        hd_write;
  logic        hd_wbit;
  logic        hd_read;
  logic        hd_rbit;
  logic        row_done;
  row_metric_t row_metric;
  row_metric_t metric;
  logic        wr_ptr;
  logic        rd_ptr;
  logic        rd_en;
  logic        rd_last;
  bit_idx_t    wr_idx;
  bit_idx_t    rd_idx;

  //--------------------------------------------------------------------
  // Input side
  //--------------------------------------------------------------------

  btc_spc_row_sort row_sort (
    .iclk       (iclk),
    .ireset     (ireset),
    .ival       (ival),
    .istrb      (istrb),
    .iLLR       (iLLR),
    .iLextr     (iLextr),
    .ialpha     (ialpha),
    .wr_idx     (wr_idx),
    .mem_write  (mem_write),
    .mem_wdat   (mem_wdat),
    .hd_write   (hd_write),
    .hd_bit     (hd_wbit),
    .row_done   (row_done),
    .row_metric (row_metric)
  );

  // Counts the registered writes, row_done marks their eop
  btc_spc_bit_counter bit_counter (
    .iclk     (iclk),
    .ireset   (ireset),
    .istart   (istart),
    .ival     (mem_write),
    .eop      (row_done),
    .rd_en    (rd_en),
    .last_idx (metric.last_idx),
    .wr_idx   (wr_idx),
    .rd_idx   (rd_idx),
    .rd_last  (rd_last)
  );

  btc_spc_row_fsm row_fsm (
    .iclk       (iclk),
    .ireset     (ireset),
    .istart     (istart),
    .row_done   (row_done),
    .row_metric (row_metric),
    .rd_last    (rd_last),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr),
    .rd_en      (rd_en),
    .metric     (metric)
  );

  //--------------------------------------------------------------------
  // Storage and output side
  //--------------------------------------------------------------------

  btc_spc_lapri_mem lapri_mem (
    .iclk  (iclk),
    .write (mem_write),
    .waddr ({wr_ptr, wr_idx}),
    .raddr ({rd_ptr, rd_idx}),
    .wdat  (mem_wdat),
    .rdat  (mem_rdat)
  );

  btc_spc_hd_fifo hd_fifo (
    .iclk   (iclk),
    .ireset (ireset),
    .istart (istart),
    .write  (hd_write),
    .wbit   (hd_wbit),
    .read   (hd_read),
    .rbit   (hd_rbit)
  );

  btc_spc_decide decide (
    .iclk     (iclk),
    .ireset   (ireset),
    .rd_val   (rd_en),
    .rd_idx   (rd_idx),
    .metric   (metric),
    .lapri    (mem_rdat),
    .hd_bit   (hd_rbit),
    .hd_read  (hd_read),
    .oval     (oval),
    .ostrb    (ostrb),
    .oLextr   (oLextr),
    .obitdat  (obitdat),
    .obiterr  (obiterr),
    .odecfail (odecfail)
  );

endmodule

`default_nettype wire

/* verilog/btc_spc_hd_fifo.sv */
// ---------------------------------------------------------------------
// Channel hard decision FIFO, two rows deep, read in output order
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_hd_fifo
  import btc_spc_pkg::*;
(
  input  logic iclk,
  input  logic ireset,
  input  logic istart,
  input  logic write,
  input  logic wbit,
  input  logic read,
  output logic rbit
);

  logic      mem [cMEM_DEPTH];
  mem_addr_t wptr;
  mem_addr_t rptr;

  // Circular pointers, wrap naturally at depth
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr <= '0;
      rptr <= '0;
    end else if (istart) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (write) begin
        wptr <= wptr + 1'b1;
      end
      if (read) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (write) begin
      mem[wptr] <= wbit;
    end
  end

  // Head of queue visible in the pop cycle
  assign rbit = mem[rptr];

endmodule

`default_nettype wire

/* verilog/btc_spc_lapri_mem.sv */
// ---------------------------------------------------------------------
// Two-row Lapri storage with registered read
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_lapri_mem
  import btc_spc_pkg::*;
(
  input  logic      iclk,
  input  logic      write,
  input  mem_addr_t waddr,
  input  mem_addr_t raddr,
  input  extr_t     wdat,
  output extr_t     rdat
);

  // Upper address bit selects the ping-pong half
  extr_t mem [cMEM_DEPTH];

  always_ff @(posedge iclk) begin
    if (write) begin
      mem[waddr] <= wdat;
    end
  end

  // One cycle read latency
  always_ff @(posedge iclk) begin
    rdat <= mem[raddr];
  end

endmodule

`default_nettype wire

/* verilog/btc_spc_pkg.sv */
// ---------------------------------------------------------------------
// BTC SPC component decoder shared definitions
// Widths, value types, row summary struct and readout FSM states
// ---------------------------------------------------------------------
`default_nettype none

package btc_spc_pkg;

  // Datapath widths
  localparam int cLLR_W     = 5;
  localparam int cEXTR_W    = 6;
  localparam int cROW_MAX   = 32;
  localparam int cBIT_IDX_W = 5;
  localparam int cALPHA_W   = 3;

  // Two rows in flight, ping-pong halves
  localparam int cMEM_DEPTH = 2 * cROW_MAX;
  // Symmetric saturation limit of Lapri
  localparam int cMAG_MAX   = 2**(cEXTR_W-1) - 1;

  typedef logic signed [cLLR_W-1:0]    llr_t;
  typedef logic signed [cEXTR_W-1:0]   extr_t;
  typedef logic        [cEXTR_W-2:0]   mag_t;
  typedef logic        [cALPHA_W-1:0]  alpha_t;
  typedef logic        [cBIT_IDX_W-1:0] bit_idx_t;
  typedef logic        [cBIT_IDX_W:0]  mem_addr_t;

  // Row framing
  typedef struct packed {
    logic sop;
    logic eop;
  } strb_t;

  // Summary of one sorted row
  typedef struct packed {
    logic     prod_sign;
    mag_t     min0;
    bit_idx_t min0_idx;
    mag_t     min1;
    bit_idx_t last_idx;
  } row_metric_t;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_READ = 1'b1
  } row_state_t;

endpackage

`default_nettype wire

/* verilog/btc_spc_row_fsm.sv */
// ---------------------------------------------------------------------
// Readout FSM of the SPC engine
// Latches row summary and swaps ping-pong row pointers
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_row_fsm
  import btc_spc_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        istart,
  input  logic        row_done,
  input  row_metric_t row_metric,
  input  logic        rd_last,
  output logic        wr_ptr,
  output logic        rd_ptr,
  output logic        rd_en,
  output row_metric_t metric
);

  row_state_t state;
  row_state_t state_nxt;

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE : if (row_done) state_nxt = ST_READ;
      // New row may be ready right at the end of readout
      ST_READ : if (rd_last && !row_done) state_nxt = ST_IDLE;
      default : state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state  <= ST_IDLE;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else if (istart) begin
      state  <= ST_IDLE;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      state <= state_nxt;
      // Finished half goes to readout, writer moves on
      if (row_done) begin
        rd_ptr <= wr_ptr;
        wr_ptr <= ~wr_ptr;
      end
    end
  end

  // Row summary held for the whole readout
  always_ff @(posedge iclk) begin
    if (row_done) begin
      metric <= row_metric;
    end
  end

  assign rd_en = (state == ST_READ);

endmodule

`default_nettype wire

/* verilog/btc_spc_row_sort.sv */
// ---------------------------------------------------------------------
// Lapri formation and running min-sum sort of one SPC row
// Keeps product sign, min0 with its index and min1
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module btc_spc_row_sort
  import btc_spc_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        ival,
  input  strb_t       istrb,
  input  llr_t        iLLR,
  input  extr_t       iLextr,
  input  alpha_t      ialpha,
  input  bit_idx_t    wr_idx,
  output logic        mem_write,
  output extr_t       mem_wdat,
  output logic        hd_write,
  output logic        hd_bit,
  output logic        row_done,
  output row_metric_t row_metric
);

  localparam int cPROD_W = cEXTR_W + cALPHA_W + 1;
  localparam int cSUM_W  = cPROD_W + 1;

  logic signed [cPROD_W-1:0] scaled;
  logic signed [cSUM_W-1:0]  sum;
  extr_t                     lapri;

  logic        val_r;
  logic        sop_r;
  logic        eop_r;
  logic        hd_r;
  extr_t       lapri_r;
  mag_t        lapri_mag;
  row_metric_t acc;
  row_metric_t acc_nxt;

  //--------------------------------------------------------------------
  // Lapri = LLR + Lextr * alpha / 4
  //--------------------------------------------------------------------

  always_comb begin
    scaled = (iLextr * $signed({1'b0, ialpha})) >>> 2;
    sum    = iLLR + scaled;
    // Saturate to symmetric range
    if (sum > cMAG_MAX) begin
      lapri = extr_t'(cMAG_MAX);
    end else if (sum < -cMAG_MAX) begin
      lapri = extr_t'(-cMAG_MAX);
    end else begin
      lapri = extr_t'(sum);
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_r <= 1'b0;
    end else begin
      val_r <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    sop_r   <= istrb.sop;
    eop_r   <= istrb.eop;
    lapri_r <= lapri;
    // Channel hard decision, negative is 1
    hd_r    <= iLLR[cLLR_W-1];
  end

  //--------------------------------------------------------------------
  // Running sort on the registered bit
  //--------------------------------------------------------------------

  assign lapri_mag = mag_t'(lapri_r[cEXTR_W-1] ? -lapri_r : lapri_r);

  always_comb begin
    acc_nxt = acc;
    if (sop_r) begin
      // First bit of a row seeds the sort
      acc_nxt.prod_sign = lapri_r[cEXTR_W-1];
      acc_nxt.min0      = lapri_mag;
      acc_nxt.min0_idx  = wr_idx;
      acc_nxt.min1      = mag_t'(cMAG_MAX);
    end else begin
      acc_nxt.prod_sign = acc.prod_sign ^ lapri_r[cEXTR_W-1];
      if (lapri_mag < acc.min0) begin
        acc_nxt.min1     = acc.min0;
        acc_nxt.min0     = lapri_mag;
        acc_nxt.min0_idx = wr_idx;
      end else if (lapri_mag < acc.min1) begin
        acc_nxt.min1 = lapri_mag;
      end
    end
    acc_nxt.last_idx = wr_idx;
  end

  always_ff @(posedge iclk) begin
    if (val_r) begin
      acc <= acc_nxt;
    end
  end

  // Summary includes the eop bit itself
  assign row_metric = acc_nxt;
  assign row_done   = val_r & eop_r;

  assign mem_write = val_r;
  assign mem_wdat  = lapri_r;
  assign hd_write  = val_r;
  assign hd_bit    = hd_r;

endmodule

`default_nettype wire
